// ==== common/frontend_pkg.sv ====
package frontend_pkg;

  // fetch address after reset
  localparam logic [31:0] RESET_PC = 32'h1c00_0000;

  // instruction queue geometry
  localparam int unsigned QUEUE_DEPTH = 8;
  localparam int unsigned QPTR_W = $clog2(QUEUE_DEPTH);
  localparam int unsigned QCNT_W = QPTR_W + 1;

  // opcode match values, see inst_decoder for the bit ranges
  localparam logic [16:0] OPC_ADD_W  = 17'h00020;
  localparam logic [16:0] OPC_SUB_W  = 17'h00022;
  localparam logic [16:0] OPC_IDLE   = 17'h00c91;
  localparam logic [9:0]  OPC_ADDI_W = 10'h00a;
  localparam logic [9:0]  OPC_LD_W   = 10'h0a2;
  localparam logic [9:0]  OPC_ST_W   = 10'h0a6;
  localparam logic [5:0]  OPC_BEQ    = 6'h16;
  localparam logic [5:0]  OPC_BL     = 6'h15;

  typedef enum logic [3:0] {
    op_add_w,
    op_sub_w,
    op_addi_w,
    op_ld_w,
    op_st_w,
    op_beq,
    op_bl,
    op_idle,
    op_invalid
  } op_e;

  // read port 0 source
  typedef enum logic [1:0] {
    r0_none,
    r0_rk,
    r0_rd
  } r0_sel_e;

  // read port 1 source
  typedef enum logic {
    r1_none,
    r1_rj
  } r1_sel_e;

  // write register source
  typedef enum logic [1:0] {
    w_none,
    w_rd,
    w_r1
  } w_sel_e;

  typedef enum logic {
    fetch_idle,
    fetch_busy
  } fetch_state_e;

  typedef struct packed {
    logic        cyc;
    logic        stb;
    logic [31:0] adr;
  } wb_req_t;

  typedef struct packed {
    logic [63:0] dat;
    logic        ack;
  } wb_resp_t;

  typedef struct packed {
    logic        valid;
    logic [31:0] target;
  } redirect_t;

  // mask[0] low when the group was entered at its second word
  typedef struct packed {
    logic [31:0]      pc;
    logic [1:0][31:0] word;
    logic [1:0]       mask;
  } fetch_pair_t;

  typedef struct packed {
    logic [31:0] pc;
    logic [31:0] inst;
  } slot_t;

  typedef struct packed {
    logic [31:0] pc;
    logic [31:0] inst;
    op_e         op;
    logic [4:0]  r_reg0;
    logic [4:0]  r_reg1;
    logic [4:0]  w_reg;
    logic [25:0] imm;
  } decoded_inst_t;

endpackage

// ==== hw/fetch/fetch_pc_gen.sv ====
`timescale 1ns/1ps

module fetch_pc_gen (
  input  logic                   clk,
  input  logic                   rst_n,
  input  frontend_pkg::redirect_t redirect_i,
  input  logic                   wait_i,
  input  logic                   int_i,
  input  logic                   accept_i,
  output logic [31:0]            pc_o,
  output logic                   pc_valid_o
);

  logic [31:0] pc_q;
  logic        idle_q;

  // redirect wins over the sequential advance, even while idle
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc_q <= frontend_pkg::RESET_PC;
    end else if (redirect_i.valid) begin
      pc_q <= {redirect_i.target[31:2], 2'b00};
    end else if (accept_i) begin
      pc_q <= {pc_q[31:3] + 29'd1, 3'b000};
    end
  end

  // idle-wait latch, an interrupt or a redirect releases it
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      idle_q <= 1'b0;
    end else if (redirect_i.valid) begin
      idle_q <= 1'b0;
    end else if (wait_i && !int_i) begin
      idle_q <= 1'b1;
    end else if (int_i) begin
      idle_q <= 1'b0;
    end
  end

  assign pc_o       = pc_q;
  assign pc_valid_o = !idle_q;

  a_pc_aligned: assert property (@(posedge clk) disable iff (!rst_n)
    pc_o[1:0] == 2'b00);

endmodule

// ==== hw/fetch/fetch_wb_unit.sv ====
`timescale 1ns/1ps

module fetch_wb_unit (
  input  logic                              clk,
  input  logic                              rst_n,
  input  logic [31:0]                       pc_i,
  input  logic                              pc_valid_i,
  output logic                              accept_o,
  input  frontend_pkg::redirect_t           redirect_i,
  input  logic [frontend_pkg::QCNT_W-1:0]   free_slots_i,
  output frontend_pkg::wb_req_t             wb_req_o,
  input  frontend_pkg::wb_resp_t            wb_resp_i,
  output frontend_pkg::fetch_pair_t         pair_o,
  output logic                              pair_we_o
);

  frontend_pkg::fetch_state_e state_q;
  logic        drop_q;
  logic [31:0] addr_q;
  logic        busy;

  assign busy = (state_q == frontend_pkg::fetch_busy);

  // start only with room for a whole group, never on a stale pc
  assign accept_o = !busy && pc_valid_i && !redirect_i.valid &&
                    (free_slots_i >= frontend_pkg::QCNT_W'(2));

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q <= frontend_pkg::fetch_idle;
      drop_q  <= 1'b0;
    end else begin
      case (state_q)
        frontend_pkg::fetch_idle: begin
          if (accept_o) begin
            state_q <= frontend_pkg::fetch_busy;
            drop_q  <= 1'b0;
          end
        end
        frontend_pkg::fetch_busy: begin
          if (wb_resp_i.ack) begin
            state_q <= frontend_pkg::fetch_idle;
            drop_q  <= 1'b0;
          end else if (redirect_i.valid) begin
            // let the bus cycle finish, discard its data
            drop_q <= 1'b1;
          end
        end
        default: begin
          state_q <= frontend_pkg::fetch_idle;
        end
      endcase
    end
  end

  // request pc, bit 2 kept for the lane mask
  always_ff @(posedge clk) begin
    if (accept_o) begin
      addr_q <= pc_i;
    end
  end

  assign wb_req_o.cyc = busy;
  assign wb_req_o.stb = busy;
  assign wb_req_o.adr = {addr_q[31:3], 3'b000};

  assign pair_o.pc      = {addr_q[31:3], 3'b000};
  assign pair_o.word[0] = wb_resp_i.dat[31:0];
  assign pair_o.word[1] = wb_resp_i.dat[63:32];
  assign pair_o.mask    = {1'b1, !addr_q[2]};

  assign pair_we_o = busy && wb_resp_i.ack && !drop_q && !redirect_i.valid;

  a_stb_needs_cyc: assert property (@(posedge clk) disable iff (!rst_n)
    wb_req_o.stb |-> wb_req_o.cyc);

  // held request keeps cyc and address until the slave answers
  a_adr_stable: assert property (@(posedge clk) disable iff (!rst_n)
    (wb_req_o.cyc && !wb_resp_i.ack) |=> (wb_req_o.cyc && $stable(wb_req_o.adr)));

endmodule

// ==== hw/inst_queue.sv ====
`timescale 1ns/1ps

module inst_queue (
  input  logic                              clk,
  input  logic                              rst_n,
  input  logic                              flush_i,
  input  frontend_pkg::fetch_pair_t         pair_i,
  input  logic                              we_i,
  output logic [frontend_pkg::QCNT_W-1:0]   free_slots_o,
  output frontend_pkg::slot_t [1:0]         head_o,
  output logic [1:0]                        head_valid_o,
  input  logic [1:0]                        pop_num_i
);

  localparam int unsigned PW = frontend_pkg::QPTR_W;
  localparam int unsigned CW = frontend_pkg::QCNT_W;

  frontend_pkg::slot_t mem [frontend_pkg::QUEUE_DEPTH];

  logic [PW-1:0] rd_ptr_q;
  logic [PW-1:0] wr_ptr_q;
  logic [CW-1:0] count_q;
  logic [1:0]    wr_num;
  frontend_pkg::slot_t [1:0] lane;

  // lane 0 takes word 1 when the group was entered at offset 4
  always_comb begin
    lane[1].pc   = {pair_i.pc[31:3], 3'b100};
    lane[1].inst = pair_i.word[1];
    if (pair_i.mask[0]) begin
      lane[0].pc   = {pair_i.pc[31:3], 3'b000};
      lane[0].inst = pair_i.word[0];
    end else begin
      lane[0] = lane[1];
    end
    wr_num = 2'(pair_i.mask[0]) + 2'(pair_i.mask[1]);
  end

  always_ff @(posedge clk) begin
    if (we_i) begin
      mem[wr_ptr_q] <= lane[0];
      if (wr_num == 2'd2) begin
        mem[wr_ptr_q + PW'(1)] <= lane[1];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n || flush_i) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (we_i) begin
        wr_ptr_q <= wr_ptr_q + PW'(wr_num);
      end
      rd_ptr_q <= rd_ptr_q + PW'(pop_num_i);
      count_q  <= count_q + (we_i ? CW'(wr_num) : '0) - CW'(pop_num_i);
    end
  end

  assign free_slots_o    = CW'(frontend_pkg::QUEUE_DEPTH) - count_q;
  assign head_o[0]       = mem[rd_ptr_q];
  assign head_o[1]       = mem[rd_ptr_q + PW'(1)];
  assign head_valid_o[0] = (count_q >= CW'(1));
  assign head_valid_o[1] = (count_q >= CW'(2));

  a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
    (we_i && !flush_i) |-> (count_q + CW'(wr_num) <= CW'(frontend_pkg::QUEUE_DEPTH)));

endmodule

// ==== hw/decode/inst_decoder.sv ====
`timescale 1ns/1ps

module inst_decoder (
  input  frontend_pkg::slot_t         slot_i,
  output frontend_pkg::decoded_inst_t inst_o
);

  logic [31:0]           w;
  frontend_pkg::op_e     op;
  frontend_pkg::r0_sel_e r0_sel;
  frontend_pkg::r1_sel_e r1_sel;
  frontend_pkg::w_sel_e  w_sel;

  assign w = slot_i.inst;

  // longest opcode fields first
  always_comb begin
    op     = frontend_pkg::op_invalid;
    r0_sel = frontend_pkg::r0_none;
    r1_sel = frontend_pkg::r1_none;
    w_sel  = frontend_pkg::w_none;
    if (w[31:15] == frontend_pkg::OPC_ADD_W || w[31:15] == frontend_pkg::OPC_SUB_W) begin
      op     = (w[31:15] == frontend_pkg::OPC_ADD_W) ? frontend_pkg::op_add_w
                                                      : frontend_pkg::op_sub_w;
      r0_sel = frontend_pkg::r0_rk;
      r1_sel = frontend_pkg::r1_rj;
      w_sel  = frontend_pkg::w_rd;
    end else if (w[31:15] == frontend_pkg::OPC_IDLE) begin
      op = frontend_pkg::op_idle;
    end else if (w[31:22] == frontend_pkg::OPC_ADDI_W || w[31:22] == frontend_pkg::OPC_LD_W) begin
      op     = (w[31:22] == frontend_pkg::OPC_ADDI_W) ? frontend_pkg::op_addi_w
                                                       : frontend_pkg::op_ld_w;
      r1_sel = frontend_pkg::r1_rj;
      w_sel  = frontend_pkg::w_rd;
    end else if (w[31:22] == frontend_pkg::OPC_ST_W || w[31:26] == frontend_pkg::OPC_BEQ) begin
      // store data and branch compare both read rd
      op     = (w[31:22] == frontend_pkg::OPC_ST_W) ? frontend_pkg::op_st_w
                                                     : frontend_pkg::op_beq;
      r0_sel = frontend_pkg::r0_rd;
      r1_sel = frontend_pkg::r1_rj;
    end else if (w[31:26] == frontend_pkg::OPC_BL) begin
      op    = frontend_pkg::op_bl;
      w_sel = frontend_pkg::w_r1;
    end
  end

  always_comb begin
    inst_o.pc   = slot_i.pc;
    inst_o.inst = w;
    inst_o.op   = op;
    inst_o.imm  = w[25:0];
    case (r0_sel)
      frontend_pkg::r0_rk: inst_o.r_reg0 = w[14:10];
      frontend_pkg::r0_rd: inst_o.r_reg0 = w[4:0];
      default:             inst_o.r_reg0 = 5'd0;
    endcase
    case (r1_sel)
      frontend_pkg::r1_rj: inst_o.r_reg1 = w[9:5];
      default:             inst_o.r_reg1 = 5'd0;
    endcase
    case (w_sel)
      frontend_pkg::w_rd: inst_o.w_reg = w[4:0];
      frontend_pkg::w_r1: inst_o.w_reg = 5'd1;
      default:            inst_o.w_reg = 5'd0;
    endcase
  end

endmodule

// ==== hw/decode/issue_buffer.sv ====
`timescale 1ns/1ps

module issue_buffer (
  input  logic                              clk,
  input  logic                              rst_n,
  input  logic                              flush_i,
  input  frontend_pkg::decoded_inst_t [1:0] dec_i,
  input  logic [1:0]                        dec_valid_i,
  input  logic [1:0]                        issue_i,
  output logic [1:0]                        pop_num_o,
  output frontend_pkg::decoded_inst_t [1:0] inst_o,
  output logic [1:0]                        inst_valid_o
);

  frontend_pkg::decoded_inst_t [1:0] slot_q;
  frontend_pkg::decoded_inst_t [1:0] rem;
  frontend_pkg::decoded_inst_t [1:0] slot_d;
  logic [1:0] valid_q;
  logic [1:0] rem_valid;
  logic [1:0] valid_d;

  // what stays after the backend takes its slots, packed toward slot 0
  always_comb begin
    rem       = slot_q;
    rem_valid = valid_q;
    case (issue_i)
      2'b01: begin
        rem[0]    = slot_q[1];
        rem_valid = {1'b0, valid_q[1]};
      end
      2'b11: begin
        rem_valid = 2'b00;
      end
      default: begin
        rem_valid = valid_q;
      end
    endcase
  end

  // refill the empty slots from the decoded queue heads
  always_comb begin
    slot_d    = rem;
    valid_d   = rem_valid;
    pop_num_o = 2'd0;
    if (!rem_valid[0]) begin
      slot_d    = dec_i;
      valid_d   = dec_valid_i;
      pop_num_o = 2'(dec_valid_i[0]) + 2'(dec_valid_i[1]);
    end else if (!rem_valid[1]) begin
      slot_d[1]  = dec_i[0];
      valid_d[1] = dec_valid_i[0];
      pop_num_o  = 2'(dec_valid_i[0]);
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n || flush_i) begin
      valid_q <= 2'b00;
    end else begin
      valid_q <= valid_d;
    end
  end

  always_ff @(posedge clk) begin
    slot_q <= slot_d;
  end

  assign inst_o       = slot_q;
  assign inst_valid_o = valid_q;

  a_issue_legal: assert property (@(posedge clk) disable iff (!rst_n)
    ((issue_i & ~valid_q) == 2'b00) && (!issue_i[1] || issue_i[0]));

endmodule

// ==== hw/frontend_top.sv ====
`timescale 1ns/1ps

module frontend_top (
  input  logic                              clk,
  input  logic                              rst_n,
  input  frontend_pkg::redirect_t           redirect_i,
  input  logic [1:0]                        issue_i,
  input  logic                              wait_i,
  input  logic                              int_i,
  output frontend_pkg::wb_req_t             wb_req_o,
  input  frontend_pkg::wb_resp_t            wb_resp_i,
  output frontend_pkg::decoded_inst_t [1:0] inst_o,
  output logic [1:0]                        inst_valid_o
);

  logic [31:0] fetch_pc;
  logic        fetch_pc_valid;
  logic        fetch_accept;
  logic [frontend_pkg::QCNT_W-1:0] free_slots;
  frontend_pkg::fetch_pair_t pair;
  logic        pair_we;
  frontend_pkg::slot_t [1:0]         head;
  logic [1:0]  head_valid;
  logic [1:0]  pop_num;
  frontend_pkg::decoded_inst_t [1:0] dec;

  fetch_pc_gen fetch_pc_gen_inst (
    .clk        (clk),
    .rst_n      (rst_n),
    .redirect_i (redirect_i),
    .wait_i     (wait_i),
    .int_i      (int_i),
    .accept_i   (fetch_accept),
    .pc_o       (fetch_pc),
    .pc_valid_o (fetch_pc_valid)
  );

  fetch_wb_unit fetch_wb_unit_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .pc_i         (fetch_pc),
    .pc_valid_i   (fetch_pc_valid),
    .accept_o     (fetch_accept),
    .redirect_i   (redirect_i),
    .free_slots_i (free_slots),
    .wb_req_o     (wb_req_o),
    .wb_resp_i    (wb_resp_i),
    .pair_o       (pair),
    .pair_we_o    (pair_we)
  );

  inst_queue inst_queue_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .flush_i      (redirect_i.valid),
    .pair_i       (pair),
    .we_i         (pair_we),
    .free_slots_o (free_slots),
    .head_o       (head),
    .head_valid_o (head_valid),
    .pop_num_i    (pop_num)
  );

  // one decoder per queue head
  inst_decoder inst_decoder_0_inst (
    .slot_i (head[0]),
    .inst_o (dec[0])
  );

  inst_decoder inst_decoder_1_inst (
    .slot_i (head[1]),
    .inst_o (dec[1])
  );

  issue_buffer issue_buffer_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .flush_i      (redirect_i.valid),
    .dec_i        (dec),
    .dec_valid_i  (head_valid),
    .issue_i      (issue_i),
    .pop_num_o    (pop_num),
    .inst_o       (inst_o),
    .inst_valid_o (inst_valid_o)
  );

endmodule

// ==== dv/frontend_mem_model.sv ====
`timescale 1ns/1ps

module frontend_mem_model (
  input  logic                   clk,
  input  logic                   rst_n,
  input  frontend_pkg::wb_req_t  wb_req_i,
  output frontend_pkg::wb_resp_t wb_resp_o
);

  logic [31:0] lfsr_q;
  logic [31:0] lfsr_1;
  logic [31:0] lfsr_2;
  logic [1:0]  delay_q;
  logic [1:0]  wait_q;
  logic        req;

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // template picked by word index within a 32-byte block
  function automatic logic [31:0] word_at(input logic [31:0] a);
    logic [31:0] base;
    case (a[4:2])
      3'd0:    base = 32'h0010_0000;
      3'd1:    base = 32'h0011_0000;
      3'd2:    base = 32'h0280_0000;
      3'd3:    base = 32'h2880_0000;
      3'd4:    base = 32'h2980_0000;
      3'd5:    base = 32'h5800_0000;
      3'd6:    base = 32'h5400_0000;
      default: base = 32'hfc00_0000;
    endcase
    // rk, rj and rd come from the address
    return base | {17'd0, a[19:15], a[14:10], a[9:5]};
  endfunction

  assign req    = wb_req_i.cyc && wb_req_i.stb;
  assign lfsr_1 = lfsr_next(lfsr_q);
  assign lfsr_2 = lfsr_next(lfsr_1);

  assign wb_resp_o.ack = req && (wait_q == delay_q);
  assign wb_resp_o.dat = {word_at(wb_req_i.adr + 32'd4), word_at(wb_req_i.adr)};

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      lfsr_q  <= 32'd68166;
      delay_q <= 2'd0;
      wait_q  <= 2'd0;
    end else if (wb_resp_o.ack) begin
      // two fresh bits set the ack delay of the next request
      delay_q <= {lfsr_1[0], lfsr_q[0]};
      lfsr_q  <= lfsr_2;
      wait_q  <= 2'd0;
    end else if (req) begin
      wait_q <= wait_q + 2'd1;
    end
  end

endmodule

// ==== dv/frontend_tb.sv ====
`timescale 1ns/1ps

module frontend_tb;

  logic clk = 1'b0;
  logic rst_n;
  frontend_pkg::redirect_t           redirect;
  logic [1:0]                        issue;
  logic                              wait_in;
  logic                              int_in;
  frontend_pkg::wb_req_t             wb_req;
  frontend_pkg::wb_resp_t            wb_resp;
  frontend_pkg::decoded_inst_t [1:0] inst;
  logic [1:0]                        inst_valid;

  // reference state
  logic [31:0] exp_pc;
  int          issued;
  logic        idle_hold;
  frontend_pkg::decoded_inst_t exp_head0;
  frontend_pkg::decoded_inst_t exp_head1;

  always #5 clk = ~clk;

  frontend_top frontend_top_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .redirect_i   (redirect),
    .issue_i      (issue),
    .wait_i       (wait_in),
    .int_i        (int_in),
    .wb_req_o     (wb_req),
    .wb_resp_i    (wb_resp),
    .inst_o       (inst),
    .inst_valid_o (inst_valid)
  );

  frontend_mem_model frontend_mem_model_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .wb_req_i  (wb_req),
    .wb_resp_o (wb_resp)
  );

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // memory contents and decode result for one pc
  function automatic frontend_pkg::decoded_inst_t expected_decode(input logic [31:0] pc);
    frontend_pkg::decoded_inst_t d;
    logic [31:0] base;
    logic [4:0]  rd;
    logic [4:0]  rj;
    logic [4:0]  rk;
    rd = pc[9:5];
    rj = pc[14:10];
    rk = pc[19:15];
    d  = '0;
    case (pc[4:2])
      3'd0: begin
        base = 32'h0010_0000;
        d.op = frontend_pkg::op_add_w;
        d.r_reg0 = rk;
        d.r_reg1 = rj;
        d.w_reg = rd;
      end
      3'd1: begin
        base = 32'h0011_0000;
        d.op = frontend_pkg::op_sub_w;
        d.r_reg0 = rk;
        d.r_reg1 = rj;
        d.w_reg = rd;
      end
      3'd2: begin
        base = 32'h0280_0000;
        d.op = frontend_pkg::op_addi_w;
        d.r_reg1 = rj;
        d.w_reg = rd;
      end
      3'd3: begin
        base = 32'h2880_0000;
        d.op = frontend_pkg::op_ld_w;
        d.r_reg1 = rj;
        d.w_reg = rd;
      end
      3'd4: begin
        base = 32'h2980_0000;
        d.op = frontend_pkg::op_st_w;
        d.r_reg0 = rd;
        d.r_reg1 = rj;
      end
      3'd5: begin
        base = 32'h5800_0000;
        d.op = frontend_pkg::op_beq;
        d.r_reg0 = rd;
        d.r_reg1 = rj;
      end
      3'd6: begin
        base = 32'h5400_0000;
        d.op = frontend_pkg::op_bl;
        d.w_reg = 5'd1;
      end
      default: begin
        base = 32'hfc00_0000;
        d.op = frontend_pkg::op_invalid;
      end
    endcase
    d.pc   = pc;
    d.inst = base | {17'd0, rk, rj, rd};
    d.imm  = d.inst[25:0];
    return d;
  endfunction

  task automatic stop_on_error(input string line);
    $display("TESTBENCH FAILED");
    $display("%s", line);
    $fatal(1, "stopped at first error");
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic wait_issued(input int count, input string what);
    int goal;
    int t;
    goal = issued + count;
    t = 0;
    while (issued < goal && t < 3000) begin
      next_cycle();
      t++;
    end
    if (issued < goal) begin
      stop_on_error($sformatf("timeout waiting for issued instructions during %s", what));
    end
  endtask

  task automatic drive_redirect(input logic [31:0] target);
    redirect.valid  = 1'b1;
    redirect.target = target;
    next_cycle();
    redirect = '0;
  endtask

  // pc advances by one word per issued instruction
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      exp_pc <= frontend_pkg::RESET_PC;
      issued <= 0;
    end else begin
      if (redirect.valid) begin
        exp_pc <= {redirect.target[31:2], 2'b00};
      end else begin
        exp_pc <= exp_pc + {28'd0, 2'(issue[0]) + 2'(issue[1]), 2'b00};
      end
      issued <= issued + int'(issue[0]) + int'(issue[1]);
    end
  end

  assign exp_head0 = expected_decode(exp_pc);
  assign exp_head1 = expected_decode(exp_pc + 32'd4);

  a_reset_quiet: assert property (@(posedge clk)
    !rst_n |=> (inst_valid == 2'b00 && !wb_req.cyc && !wb_req.stb))
    else stop_on_error("outputs not cleared after reset");

  a_head0: assert property (@(posedge clk) disable iff (!rst_n)
    inst_valid[0] |-> inst[0] == exp_head0)
    else stop_on_error($sformatf("mismatch slot0_fetch expected %h actual %h",
                                 $sampled(exp_head0), $sampled(inst[0])));

  a_head1: assert property (@(posedge clk) disable iff (!rst_n)
    inst_valid[1] |-> inst[1] == exp_head1)
    else stop_on_error($sformatf("mismatch slot1_fetch expected %h actual %h",
                                 $sampled(exp_head1), $sampled(inst[1])));

  a_redirect_flush: assert property (@(posedge clk) disable iff (!rst_n)
    redirect.valid |=> inst_valid == 2'b00)
    else stop_on_error($sformatf("mismatch redirect_flush expected 00 actual %b",
                                 $sampled(inst_valid)));

  a_wb_stb: assert property (@(posedge clk) disable iff (!rst_n)
    wb_req.stb |-> wb_req.cyc)
    else stop_on_error("wishbone stb high without cyc");

  a_wb_hold: assert property (@(posedge clk) disable iff (!rst_n)
    (wb_req.cyc && !wb_resp.ack) |=> (wb_req.cyc && wb_req.stb && $stable(wb_req.adr)))
    else stop_on_error("wishbone request dropped or changed before ack");

  a_wb_end: assert property (@(posedge clk) disable iff (!rst_n)
    (wb_req.cyc && wb_resp.ack) |=> !wb_req.cyc)
    else stop_on_error("wishbone cyc still high in the cycle after ack");

  a_wb_align: assert property (@(posedge clk) disable iff (!rst_n)
    wb_req.cyc |-> wb_req.adr[2:0] == 3'b000)
    else stop_on_error("wishbone address not 8-byte aligned");

  a_idle_quiet: assert property (@(posedge clk) disable iff (!rst_n)
    idle_hold |-> !wb_req.cyc)
    else stop_on_error("fetch started while waiting for an interrupt");

  // backend issue pattern, legal by construction
  initial begin
    logic [31:0] lfsr_state;
    logic [2:0]  r;
    logic        go0;
    lfsr_state = 32'd68166;
    issue = 2'b00;
    forever begin
      next_cycle();
      for (int i = 0; i < 3; i++) begin
        r[i] = lfsr_state[0];
        lfsr_state = lfsr_next(lfsr_state);
      end
      go0 = rst_n && inst_valid[0] && (r[0] || r[1]);
      issue = {go0 && inst_valid[1] && r[2], go0};
    end
  end

  initial begin
    int t;
    rst_n     = 1'b0;
    redirect  = '0;
    wait_in   = 1'b0;
    int_in    = 1'b0;
    idle_hold = 1'b0;
    repeat (16) @(posedge clk);
    #1;
    rst_n = 1'b1;

    wait_issued(48, "sequential fetch");
    drive_redirect(32'h1c00_1004);
    wait_issued(24, "redirect to offset 4");
    // low bits of the target get dropped
    drive_redirect(32'h1c00_3002);
    wait_issued(24, "unaligned redirect");

    // catch a bus cycle still waiting for ack
    t = 0;
    while (!(wb_req.cyc && !wb_resp.ack) && t < 200) begin
      next_cycle();
      t++;
    end
    if (!(wb_req.cyc && !wb_resp.ack)) begin
      stop_on_error("timeout waiting for an open bus cycle");
    end
    drive_redirect(32'h1c00_4000);
    wait_issued(24, "redirect during a bus cycle");

    wait_in = 1'b1;
    next_cycle();
    wait_in = 1'b0;
    t = 0;
    while (wb_req.cyc && t < 50) begin
      next_cycle();
      t++;
    end
    if (wb_req.cyc) begin
      stop_on_error("timeout waiting for the last bus cycle before idle");
    end
    idle_hold = 1'b1;
    repeat (25) next_cycle();
    idle_hold = 1'b0;

    int_in = 1'b1;
    next_cycle();
    int_in = 1'b0;
    t = 0;
    while (!wb_req.cyc && t < 50) begin
      next_cycle();
      t++;
    end
    if (!wb_req.cyc) begin
      stop_on_error("fetch did not resume after the interrupt");
    end
    wait_issued(24, "fetch after interrupt");

    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

// ==== compile.f ====
common/frontend_pkg.sv
hw/fetch/fetch_pc_gen.sv
hw/fetch/fetch_wb_unit.sv
hw/inst_queue.sv
hw/decode/inst_decoder.sv
hw/decode/issue_buffer.sv
hw/frontend_top.sv
dv/frontend_mem_model.sv
dv/frontend_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
TOP       ?= frontend_tb
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
